// File: all.f
rtl/axi_pkg.sv
rtl/mem_pkg.sv
rtl/axi_mem_array.sv
rtl/axi_wr_ctrl.sv
rtl/axi_rd_ctrl.sv
rtl/axi_mem_top.sv
sim/tb_clock_gen.sv
sim/axi_mem_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := axi_mem_tb
FILELIST  := all.f
BUILD_DIR := obj_dir
SIM_BIN   := $(BUILD_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes.
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: sim/axi_mem_tb.sv
// Table-driven testbench for the AXI slave memory with a byte-wise shadow model.
module axi_mem_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import axi_pkg::*;
  import mem_pkg::*;

  localparam int        WAIT_LIMIT = 40;
  localparam axi_data_t FILL_WORD  = 64'hdeadbeef_deadbeef;

  typedef enum logic {KIND_WRITE, KIND_READ} kind_e;

  typedef struct packed {
    kind_e       kind;
    logic        stall;
    axi_id_t     id;
    axi_addr_t   addr;
    axi_len_t    len;
    axi_strb_t   strb;
    logic [31:0] dseed;
  } test_t;

  logic      clk;
  logic      reset;
  axi_id_t   awid;
  axi_addr_t awaddr;
  logic      awvalid;
  logic      awready;
  axi_data_t wdata;
  axi_strb_t wstrb;
  logic      wlast;
  logic      wvalid;
  logic      wready;
  axi_id_t   bid;
  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;
  axi_id_t   arid;
  axi_addr_t araddr;
  axi_len_t  arlen;
  logic      arvalid;
  logic      arready;
  axi_id_t   rid;
  axi_data_t rdata;
  axi_resp_t rresp;
  logic      rlast;
  logic      rvalid;
  logic      rready;

  test_t      tests [$];
  string      names [$];
  logic [7:0] shadow_bytes [MEM_ELS][AXI_STRB_W];
  bit         shadow_written [MEM_ELS];

  integer seed;
  int     pass_count;
  int     fail_count;
  int     test_errors;
  bit     timed_out;

  tb_clock_gen u_clk (.clk_o(clk), .reset_o(reset));

  axi_mem_top u_dut (
    .clk_i (clk), .reset_i (reset),
    .awid_i (awid), .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
    .wdata_i (wdata), .wstrb_i (wstrb), .wlast_i (wlast), .wvalid_i (wvalid),
    .wready_o (wready),
    .bid_o (bid), .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
    .arid_i (arid), .araddr_i (araddr), .arlen_i (arlen), .arvalid_i (arvalid),
    .arready_o (arready),
    .rid_o (rid), .rdata_o (rdata), .rresp_o (rresp), .rlast_o (rlast),
    .rvalid_o (rvalid), .rready_i (rready)
  );

  task automatic check_data(input string name, input axi_data_t expected,
                            input axi_data_t actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_id(input string name, input axi_id_t expected, input axi_id_t actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_t expected,
                            input axi_resp_t actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("error %s: expected %b, actual %b", name, expected, actual);
      fail_count++;
      test_errors++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic report_timeout(input string name, input string what);
    $display("%s: no %s within %0d cycles, the DUT stopped responding", name, what, WAIT_LIMIT);
    timed_out = 1'b1;
  endtask

  task automatic add_test(input string name, input kind_e kind, input logic stall,
                          input axi_id_t id, input axi_addr_t addr, input axi_len_t len,
                          input axi_strb_t strb, input logic [31:0] dseed);
    test_t t;
    t = '{kind, stall, id, addr, len, strb, dseed};
    tests.push_back(t);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_test("single_wr",  KIND_WRITE, 1'b0, 4'h3, 32'h0000_0040, 8'd0, 8'hff, 32'h0101);
    add_test("single_rd",  KIND_READ,  1'b0, 4'h5, 32'h0000_0040, 8'd0, 8'h00, 32'h0);
    add_test("burst_wr",   KIND_WRITE, 1'b0, 4'h1, 32'h0000_0100, 8'd3, 8'hff, 32'h0202);
    add_test("burst_rd",   KIND_READ,  1'b0, 4'h2, 32'h0000_0100, 8'd3, 8'h00, 32'h0);
    add_test("strb_lo_wr", KIND_WRITE, 1'b0, 4'h4, 32'h0000_0200, 8'd0, 8'h0f, 32'h0303);
    add_test("strb_hi_wr", KIND_WRITE, 1'b0, 4'h6, 32'h0000_0200, 8'd0, 8'hf0, 32'h0404);
    add_test("strb_rd",    KIND_READ,  1'b0, 4'h7, 32'h0000_0200, 8'd0, 8'h00, 32'h0);
    add_test("fill_rd",    KIND_READ,  1'b0, 4'h8, 32'h0000_0300, 8'd1, 8'h00, 32'h0);
    add_test("alias_rd",   KIND_READ,  1'b0, 4'h9, 32'h0000_0840, 8'd0, 8'h00, 32'h0);
    add_test("wrap_wr",    KIND_WRITE, 1'b0, 4'ha, 32'h0000_07f8, 8'd1, 8'hff, 32'h0505);
    add_test("wrap_rd",    KIND_READ,  1'b0, 4'hb, 32'h0000_07f8, 8'd1, 8'h00, 32'h0);
    add_test("high_rd",    KIND_READ,  1'b0, 4'hc, 32'h0000_0800, 8'd0, 8'h00, 32'h0);
    add_test("bp_wr",      KIND_WRITE, 1'b1, 4'hd, 32'h0000_0400, 8'd2, 8'hff, 32'h0606);
    add_test("bp_rd",      KIND_READ,  1'b1, 4'he, 32'h0000_0400, 8'd2, 8'h00, 32'h0);
    add_test("bp_fill_rd", KIND_READ,  1'b1, 4'hf, 32'h0000_0500, 8'd1, 8'h00, 32'h0);
  endtask

  task automatic init_shadow();
    for (int w = 0; w < MEM_ELS; w++) begin
      for (int b = 0; b < AXI_STRB_W; b++) begin
        shadow_bytes[w][b] = FILL_WORD[b*8 +: 8]; // Unstrobed lanes of a first write.
      end
      shadow_written[w] = 1'b0;
    end
  endtask

  task automatic store_beat(input int idx, input axi_data_t data, input axi_strb_t strb);
    for (int b = 0; b < AXI_STRB_W; b++) begin
      if (strb[b]) begin
        shadow_bytes[idx][b] = data[b*8 +: 8];
      end
    end
    shadow_written[idx] = 1'b1;
  endtask

  function automatic axi_data_t expected_word(input int idx);
    axi_data_t w;
    if (!shadow_written[idx]) begin
      return FILL_WORD;
    end
    for (int b = 0; b < AXI_STRB_W; b++) begin
      w[b*8 +: 8] = shadow_bytes[idx][b];
    end
    return w;
  endfunction

  // Drops the offset bits and wraps the index modulo the depth.
  function automatic int word_of(input axi_addr_t addr);
    return int'((addr >> BYTE_OFF_W) % MEM_ELS);
  endfunction

  function automatic int draw_stall();
    return ($random(seed) & 32'h7fff_ffff) % 6;
  endfunction

  task automatic check_idle(input string name);
    check_flag($sformatf("%s awready", name), 1'b0, awready);
    check_flag($sformatf("%s wready", name), 1'b0, wready);
    check_flag($sformatf("%s bvalid", name), 1'b0, bvalid);
    check_flag($sformatf("%s arready", name), 1'b0, arready);
    check_flag($sformatf("%s rvalid", name), 1'b0, rvalid);
  endtask

  task automatic check_reset();
    int cycles;
    @(negedge clk);
    cycles = 0;
    while (reset && cycles < WAIT_LIMIT) begin
      check_idle("in reset");
      @(negedge clk);
      cycles++;
    end
    if (reset) begin
      report_timeout("reset", "reset release");
      return;
    end
    check_idle("after reset");
    cycles = 0;
    while (!(awready && arready) && cycles < 3) begin
      @(negedge clk);
      cycles++;
    end
    check_flag("reset awready", 1'b1, awready);
    check_flag("reset arready", 1'b1, arready);
  endtask

  task automatic run_write(input string name, input test_t t);
    int          cycles;
    int          idx;
    int          stall;
    axi_data_t   data;
    logic [31:0] hi;
    logic [31:0] lo;
    idx = word_of(t.addr);
    @(posedge clk);
    awid    <= t.id;
    awaddr  <= t.addr;
    awvalid <= 1'b1;
    @(negedge clk);
    cycles = 0;
    while (!awready && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!awready) begin
      report_timeout(name, "awready");
      return;
    end
    for (int k = 0; k <= int'(t.len); k++) begin
      hi   = $random(seed);
      lo   = $random(seed);
      data = {hi, lo ^ t.dseed};
      @(posedge clk); // AW or previous W handshake.
      awvalid <= 1'b0;
      wdata   <= data;
      wstrb   <= t.strb;
      wlast   <= (k == int'(t.len));
      wvalid  <= 1'b1;
      @(negedge clk);
      cycles = 0;
      while (!wready && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (!wready) begin
        report_timeout(name, "wready");
        return;
      end
      store_beat(idx, data, t.strb);
      idx = (idx + 1) % MEM_ELS;
    end
    @(posedge clk);
    wvalid <= 1'b0;
    wlast  <= 1'b0;
    bready <= !t.stall;
    @(negedge clk);
    cycles = 0;
    while (!bvalid && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!bvalid) begin
      report_timeout(name, "bvalid");
      return;
    end
    check_id($sformatf("%s bid", name), t.id, bid);
    check_resp($sformatf("%s bresp", name), AXI_RESP_OKAY, bresp);
    if (t.stall) begin
      stall = draw_stall() + 1;
      for (int s = 0; s < stall; s++) begin
        @(posedge clk);
        @(negedge clk);
        check_flag($sformatf("%s bvalid held", name), 1'b1, bvalid);
        check_id($sformatf("%s bid held", name), t.id, bid);
        check_resp($sformatf("%s bresp held", name), AXI_RESP_OKAY, bresp);
      end
      @(posedge clk);
      bready <= 1'b1;
      @(negedge clk);
    end
    @(posedge clk); // B handshake.
    bready <= 1'b0;
    @(negedge clk);
    check_flag($sformatf("%s bvalid after", name), 1'b0, bvalid);
    check_flag($sformatf("%s awready after", name), 1'b1, awready);
  endtask

  task automatic run_read(input string name, input test_t t);
    int        cycles;
    int        idx;
    int        stall;
    axi_data_t held_data;
    logic      held_last;
    idx   = word_of(t.addr);
    stall = t.stall ? draw_stall() : 0;
    @(posedge clk);
    arid    <= t.id;
    araddr  <= t.addr;
    arlen   <= t.len;
    arvalid <= 1'b1;
    rready  <= (stall == 0);
    @(negedge clk);
    cycles = 0;
    while (!arready && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!arready) begin
      report_timeout(name, "arready");
      return;
    end
    @(posedge clk); // AR handshake.
    arvalid <= 1'b0;
    arlen   <= ~t.len; // Burst keeps the latched length.
    for (int k = 0; k <= int'(t.len); k++) begin
      @(negedge clk);
      cycles = 0;
      while (!rvalid && cycles < WAIT_LIMIT) begin
        @(negedge clk);
        cycles++;
      end
      if (!rvalid) begin
        report_timeout(name, "rvalid");
        return;
      end
      check_data($sformatf("%s beat %0d rdata", name, k), expected_word(idx), rdata);
      check_id($sformatf("%s beat %0d rid", name, k), t.id, rid);
      check_resp($sformatf("%s beat %0d rresp", name, k), AXI_RESP_OKAY, rresp);
      check_flag($sformatf("%s beat %0d rlast", name, k), k == int'(t.len), rlast);
      held_data = rdata;
      held_last = rlast;
      for (int s = 0; s < stall; s++) begin
        @(posedge clk);
        if (s == stall - 1) begin
          rready <= 1'b1;
        end
        @(negedge clk);
        check_flag($sformatf("%s beat %0d rvalid held", name, k), 1'b1, rvalid);
        check_data($sformatf("%s beat %0d rdata held", name, k), held_data, rdata);
        check_flag($sformatf("%s beat %0d rlast held", name, k), held_last, rlast);
        check_id($sformatf("%s beat %0d rid held", name, k), t.id, rid);
        check_resp($sformatf("%s beat %0d rresp held", name, k), AXI_RESP_OKAY, rresp);
      end
      @(posedge clk); // R handshake.
      idx    = (idx + 1) % MEM_ELS;
      stall  = (t.stall && k < int'(t.len)) ? draw_stall() : 0;
      rready <= (k < int'(t.len)) && (stall == 0);
    end
    @(negedge clk);
    check_flag($sformatf("%s rvalid after", name), 1'b0, rvalid);
    check_flag($sformatf("%s arready after", name), 1'b1, arready);
  endtask

  task automatic report_test(input string name);
    $display("test %-12s %s", name, (test_errors == 0 && !timed_out) ? "ok" : "failed");
  endtask

  initial begin
    seed        = 32'h1b43;
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    timed_out   = 1'b0;
    awid    = '0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wlast   = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    arid    = '0;
    araddr  = '0;
    arlen   = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    init_shadow();
    build_table();
    check_reset();
    report_test("reset");
    if (!timed_out) begin
      for (int i = 0; i < tests.size(); i++) begin
        test_errors = 0;
        if (tests[i].kind == KIND_WRITE) begin
          run_write(names[i], tests[i]);
        end else begin
          run_read(names[i], tests[i]);
        end
        report_test(names[i]);
        if (timed_out) begin
          break;
        end
      end
    end
    $display("pass count %0d, fail count %0d", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: sim/tb_clock_gen.sv
// Testbench clock and reset source, 4 ns clock with reset held for 8 cycles.
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 8;

  initial begin
    clk_o = 1'b0;
    forever begin
      #2 clk_o = ~clk_o; // Half period.
    end
  end

  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

// File: rtl/axi_mem_top.sv
// AXI slave memory top level joining the write and read controllers to one word array.
module axi_mem_top (
  input  logic               clk_i,
  input  logic               reset_i,

  // Write address channel.
  input  axi_pkg::axi_id_t   awid_i,
  input  axi_pkg::axi_addr_t awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,

  // Write data channel.
  input  axi_pkg::axi_data_t wdata_i,
  input  axi_pkg::axi_strb_t wstrb_i,
  input  logic               wlast_i,
  input  logic               wvalid_i,
  output logic               wready_o,

  // Write response channel.
  output axi_pkg::axi_id_t   bid_o,
  output axi_pkg::axi_resp_t bresp_o,
  output logic               bvalid_o,
  input  logic               bready_i,

  // Read address channel.
  input  axi_pkg::axi_id_t   arid_i,
  input  axi_pkg::axi_addr_t araddr_i,
  input  axi_pkg::axi_len_t  arlen_i,
  input  logic               arvalid_i,
  output logic               arready_o,

  // Read data channel.
  output axi_pkg::axi_id_t   rid_o,
  output axi_pkg::axi_data_t rdata_o,
  output axi_pkg::axi_resp_t rresp_o,
  output logic               rlast_o,
  output logic               rvalid_o,
  input  logic               rready_i
);
  import axi_pkg::*;
  import mem_pkg::*;

  logic      wr_en;
  mem_idx_t  wr_idx;
  axi_data_t wr_data;
  axi_strb_t wr_strb;
  mem_idx_t  rd_idx;
  axi_data_t rd_data;

  axi_wr_ctrl u_wr (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .awid_i    (awid_i),
    .awaddr_i  (awaddr_i),
    .awvalid_i (awvalid_i),
    .awready_o (awready_o),
    .wdata_i   (wdata_i),
    .wstrb_i   (wstrb_i),
    .wlast_i   (wlast_i),
    .wvalid_i  (wvalid_i),
    .wready_o  (wready_o),
    .bid_o     (bid_o),
    .bresp_o   (bresp_o),
    .bvalid_o  (bvalid_o),
    .bready_i  (bready_i),
    .wr_en_o   (wr_en),
    .wr_idx_o  (wr_idx),
    .wr_data_o (wr_data),
    .wr_strb_o (wr_strb)
  );

  axi_rd_ctrl u_rd (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .arid_i    (arid_i),
    .araddr_i  (araddr_i),
    .arlen_i   (arlen_i),
    .arvalid_i (arvalid_i),
    .arready_o (arready_o),
    .rid_o     (rid_o),
    .rdata_o   (rdata_o),
    .rresp_o   (rresp_o),
    .rlast_o   (rlast_o),
    .rvalid_o  (rvalid_o),
    .rready_i  (rready_i),
    .rd_idx_o  (rd_idx),
    .rd_data_i (rd_data)
  );

  axi_mem_array u_mem (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .wr_en_i   (wr_en),
    .wr_idx_i  (wr_idx),
    .wr_data_i (wr_data),
    .wr_strb_i (wr_strb),
    .rd_idx_i  (rd_idx),
    .rd_data_o (rd_data)
  );

endmodule

// File: rtl/axi_rd_ctrl.sv
// AXI read channel controller that takes an AR burst and streams the words out on R.
module axi_rd_ctrl (
  input  logic               clk_i,
  input  logic               reset_i,

  input  axi_pkg::axi_id_t   arid_i,
  input  axi_pkg::axi_addr_t araddr_i,
  input  axi_pkg::axi_len_t  arlen_i,
  input  logic               arvalid_i,
  output logic               arready_o,

  output axi_pkg::axi_id_t   rid_o,
  output axi_pkg::axi_data_t rdata_o,
  output axi_pkg::axi_resp_t rresp_o,
  output logic               rlast_o,
  output logic               rvalid_o,
  input  logic               rready_i,

  output mem_pkg::mem_idx_t  rd_idx_o,
  input  axi_pkg::axi_data_t rd_data_i
);
  import axi_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    RD_RESET,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

  rd_state_e state_r;
  rd_state_e state_n;

  axi_id_t  id_r;
  mem_idx_t idx_r;
  axi_len_t len_r;
  axi_len_t beat_r;

  logic ar_fire;
  logic r_fire;
  logic last_beat;

  assign ar_fire   = arvalid_i & arready_o;
  assign r_fire    = rvalid_o & rready_i;
  assign last_beat = (beat_r == len_r);

  always_comb begin
    state_n   = state_r;
    arready_o = 1'b0;
    rvalid_o  = 1'b0;
    case (state_r)
      RD_RESET: begin
        state_n = RD_ADDR;
      end
      RD_ADDR: begin
        arready_o = 1'b1;
        if (arvalid_i) begin
          state_n = RD_DATA;
        end
      end
      RD_DATA: begin
        rvalid_o = 1'b1;
        if (rready_i && last_beat) begin
          state_n = RD_ADDR;
        end
      end
      default: begin
        state_n = RD_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= RD_RESET;
    end else begin
      state_r <= state_n;
    end
  end

  // Length is latched so arlen_i may change during the burst.
  always_ff @(posedge clk_i) begin
    if (ar_fire) begin
      id_r   <= arid_i;
      idx_r  <= araddr_i[BYTE_OFF_W +: MEM_IDX_W];
      len_r  <= arlen_i;
      beat_r <= '0;
    end else if (r_fire) begin
      idx_r  <= idx_r + 1'b1; // Wraps at the depth.
      beat_r <= beat_r + 1'b1;
    end
  end

  // Data comes straight from the asynchronous array read.
  assign rd_idx_o = idx_r;
  assign rdata_o  = rd_data_i;
  assign rid_o    = id_r;
  assign rresp_o  = AXI_RESP_OKAY;
  assign rlast_o  = rvalid_o & last_beat;

  // A stalled beat keeps valid, payload and last flag.
  assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o && !rready_i |=>
      rvalid_o && $stable(rdata_o) && $stable(rlast_o) && $stable(rid_o));

endmodule

// File: rtl/axi_wr_ctrl.sv
// AXI write channel controller that takes AW and W bursts, drives the array and answers on B.
module axi_wr_ctrl (
  input  logic               clk_i,
  input  logic               reset_i,

  input  axi_pkg::axi_id_t   awid_i,
  input  axi_pkg::axi_addr_t awaddr_i,
  input  logic               awvalid_i,
  output logic               awready_o,

  input  axi_pkg::axi_data_t wdata_i,
  input  axi_pkg::axi_strb_t wstrb_i,
  input  logic               wlast_i,
  input  logic               wvalid_i,
  output logic               wready_o,

  output axi_pkg::axi_id_t   bid_o,
  output axi_pkg::axi_resp_t bresp_o,
  output logic               bvalid_o,
  input  logic               bready_i,

  output logic               wr_en_o,
  output mem_pkg::mem_idx_t  wr_idx_o,
  output axi_pkg::axi_data_t wr_data_o,
  output axi_pkg::axi_strb_t wr_strb_o
);
  import axi_pkg::*;
  import mem_pkg::*;

  typedef enum logic [1:0] {
    WR_RESET,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_state_e;

  wr_state_e state_r;
  wr_state_e state_n;

  axi_id_t  id_r;
  mem_idx_t idx_r;

  logic aw_fire;
  logic w_fire;

  assign aw_fire = awvalid_i & awready_o;
  assign w_fire  = wvalid_i & wready_o;

  // Handshake outputs follow the state alone.
  always_comb begin
    state_n   = state_r;
    awready_o = 1'b0;
    wready_o  = 1'b0;
    bvalid_o  = 1'b0;
    case (state_r)
      WR_RESET: begin
        state_n = WR_ADDR; // Ready stays low one cycle after reset.
      end
      WR_ADDR: begin
        awready_o = 1'b1;
        if (awvalid_i) begin
          state_n = WR_DATA;
        end
      end
      WR_DATA: begin
        wready_o = 1'b1;
        if (wvalid_i && wlast_i) begin
          state_n = WR_RESP; // The wlast beat ends the burst whatever its length.
        end
      end
      WR_RESP: begin
        bvalid_o = 1'b1;
        if (bready_i) begin
          state_n = WR_ADDR;
        end
      end
      default: begin
        state_n = WR_RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= WR_RESET;
    end else begin
      state_r <= state_n;
    end
  end

  // Word index wraps at the depth through its own width.
  always_ff @(posedge clk_i) begin
    if (aw_fire) begin
      id_r  <= awid_i;
      idx_r <= awaddr_i[BYTE_OFF_W +: MEM_IDX_W];
    end else if (w_fire) begin
      idx_r <= idx_r + 1'b1;
    end
  end

  assign bid_o   = id_r;
  assign bresp_o = AXI_RESP_OKAY;

  // Each accepted beat goes straight to the array in the same cycle.
  assign wr_en_o   = w_fire;
  assign wr_idx_o  = idx_r;
  assign wr_data_o = wdata_i;
  assign wr_strb_o = wstrb_i;

  // The response and its ID hold until the master accepts them.
  assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable(bid_o));

  assert property (@(posedge clk_i) disable iff (reset_i)
    wr_en_o && wlast_i |=> bvalid_o && !wready_o); // Response follows the last beat.

endmodule

// File: rtl/axi_mem_array.sv
// Word array with byte-strobe writes, per-word written bits and fill data for unwritten words.
module axi_mem_array (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               wr_en_i,
  input  mem_pkg::mem_idx_t  wr_idx_i,
  input  axi_pkg::axi_data_t wr_data_i,
  input  axi_pkg::axi_strb_t wr_strb_i,

  input  mem_pkg::mem_idx_t  rd_idx_i,
  output axi_pkg::axi_data_t rd_data_o
);
  import axi_pkg::*;
  import mem_pkg::*;

  axi_data_t          mem_r [MEM_ELS];
  logic [MEM_ELS-1:0] written_r;
  axi_data_t          fill_data;

  assign fill_data = {(AXI_DATA_W / 32){INIT_WORD}};

  // Lanes without a strobe take the fill pattern on the first write to a word.
  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int i = 0; i < AXI_STRB_W; i++) begin
        if (wr_strb_i[i]) begin
          mem_r[wr_idx_i][i*8 +: 8] <= wr_data_i[i*8 +: 8];
        end else if (!written_r[wr_idx_i]) begin
          mem_r[wr_idx_i][i*8 +: 8] <= fill_data[i*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      written_r <= '0;
    end else if (wr_en_i) begin
      written_r[wr_idx_i] <= 1'b1;
    end
  end

  // Asynchronous read.
  assign rd_data_o = written_r[rd_idx_i] ? mem_r[rd_idx_i] : fill_data;

  // A write with an unknown index would corrupt the whole array.
  assert property (@(posedge clk_i) disable iff (reset_i)
    wr_en_i |-> !$isunknown(wr_idx_i));

endmodule

// File: rtl/mem_pkg.sv
// Word array geometry, address split and fill pattern of the AXI memory.
package mem_pkg;

  // Depth in data words.
  localparam int MEM_ELS   = 256;
  localparam int MEM_IDX_W = $clog2(MEM_ELS);

  typedef logic [MEM_IDX_W-1:0] mem_idx_t;

  // Address bits below the word index, one 64-bit word is 8 bytes.
  localparam int BYTE_OFF_W = 3;

  // Returned for words never written since reset.
  localparam logic [31:0] INIT_WORD = 32'hdeadbeef;

endpackage

// File: rtl/axi_pkg.sv
// AXI4 channel field widths, field vector types and response codes.
package axi_pkg;

  localparam int AXI_ID_W   = 4;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = AXI_DATA_W / 8; // One strobe per byte lane.
  localparam int AXI_LEN_W  = 8;

  typedef logic [AXI_ID_W-1:0]   axi_id_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_STRB_W-1:0] axi_strb_t;
  typedef logic [AXI_LEN_W-1:0]  axi_len_t;

  // BRESP and RRESP encoding.
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

endpackage
